// ==== hdl/frontend_pkg.sv ====
// Shared widths and structs; widths are fixed here and only BTB/cache sizes are parameters
`default_nettype none

package frontend_pkg;

  // ==================================================
  // Widths and constants
  // ==================================================
  localparam int unsigned PLEN            = 32;
  localparam int unsigned ILEN            = 32;
  localparam int unsigned INSTR_PER_FETCH = 2;
  localparam int unsigned LINE_WIDTH      = 128;
  localparam int unsigned ICACHE_WAYS     = 2;

  localparam int unsigned SLOT_IDX_W      = $clog2(INSTR_PER_FETCH);
  localparam int unsigned GROUP_BYTES     = INSTR_PER_FETCH * ILEN / 8;
  localparam int unsigned GROUP_OFFSET_W  = $clog2(GROUP_BYTES);
  localparam int unsigned LINE_OFFSET_W   = $clog2(LINE_WIDTH / 8);

  localparam logic [PLEN-1:0] RESET_PC = 32'h0000_1000;

  // ==================================================
  // Structs crossing block boundaries
  // ==================================================
  typedef struct packed {
    logic [PLEN-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic [PLEN-1:0]                       npc;
    logic                                  taken_valid;
    logic [SLOT_IDX_W-1:0]                 taken_slot;
    logic [INSTR_PER_FETCH-1:0][PLEN-1:0]  slot_npc;
  } pred_t;

  typedef struct packed {
    logic [PLEN-1:0] pc;
    logic            is_cond;
    logic            taken;
    logic [PLEN-1:0] target;
  } bpu_update_t;

  // Group pc is always aligned to GROUP_BYTES
  typedef struct packed {
    logic [PLEN-1:0]                      pc;
    logic [INSTR_PER_FETCH-1:0][ILEN-1:0] instrs;
    logic [INSTR_PER_FETCH-1:0]           slot_valid;
    logic [INSTR_PER_FETCH-1:0][PLEN-1:0] pred_npc;
  } fetch_group_t;

  typedef struct packed {
    logic [PLEN-1:0] paddr;
    logic            way;
  } miss_req_t;

  typedef struct packed {
    logic [PLEN-1:0]       paddr;
    logic                  way;
    logic [LINE_WIDTH-1:0] data;
  } refill_t;

endpackage

`default_nettype wire

// ==== hdl/ifu.sv ====
// Fetch unit; one request in flight, fetch PC must be word aligned, groups use the registered pred
`timescale 1ns/100ps
`default_nettype none

module ifu
  import frontend_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 ibuf_ready_i,
  input  logic                                 flush_i,
  input  logic [PLEN-1:0]                      redirect_pc_i,
  input  logic                                 req_ready_i,
  input  pred_t                                pred_i,
  input  logic                                 rsp_valid_i,
  input  logic [INSTR_PER_FETCH-1:0][ILEN-1:0] rsp_instrs_i,
  output logic                                 fetch_valid_o,
  output fetch_req_t                           fetch_req_o,
  output logic                                 cache_flush_o,
  output logic                                 ibuf_valid_o,
  output fetch_group_t                         ibuf_group_o
);

  localparam logic [1:0] S_ISSUE   = 2'd0;
  localparam logic [1:0] S_WAIT    = 2'd1;
  localparam logic [1:0] S_PRESENT = 2'd2;

  logic [1:0]                 state_q;
  logic [1:0]                 state_d;
  logic [PLEN-1:0]            pc_q;
  logic [PLEN-1:0]            pc_d;
  logic [PLEN-1:0]            base_pc;
  logic                       req_fire;
  logic                       rsp_take;
  logic [INSTR_PER_FETCH-1:0] slot_mask;
  fetch_group_t               group_q;

  // ==================================================
  // Request side
  // ==================================================
  // No request leaves in the flush cycle, so nothing stale gets accepted
  assign fetch_valid_o   = !flush_i &&
                           ((state_q == S_ISSUE) || (state_q == S_PRESENT && ibuf_ready_i));
  assign fetch_req_o.pc  = pc_q;
  assign req_fire        = fetch_valid_o && req_ready_i;
  assign cache_flush_o   = flush_i;

  assign base_pc  = {pc_q[PLEN-1:GROUP_OFFSET_W], {GROUP_OFFSET_W{1'b0}}};
  assign rsp_take = (state_q == S_WAIT) && rsp_valid_i && !flush_i;

  // Slots before the fetch PC or after the taken slot are dropped
  always_comb begin
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      slot_mask[s] = ((base_pc + PLEN'(4 * s)) >= pc_q) &&
                     !(pred_i.taken_valid && (int'(pred_i.taken_slot) < s));
    end
  end

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    if (flush_i) begin
      state_d = S_ISSUE;
      pc_d    = redirect_pc_i;
    end else begin
      case (state_q)
        S_ISSUE: begin
          if (req_fire) begin
            state_d = S_WAIT;
          end
        end
        S_WAIT: begin
          if (rsp_valid_i) begin
            state_d = S_PRESENT;
            pc_d    = pred_i.npc;
          end
        end
        S_PRESENT: begin
          // Next group goes out in the same cycle the buffer takes this one
          if (ibuf_ready_i) begin
            state_d = req_fire ? S_WAIT : S_ISSUE;
          end
        end
        default: begin
          state_d = S_ISSUE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_ISSUE;
      pc_q    <= RESET_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  // ==================================================
  // Instruction buffer output register
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (rsp_take) begin
      group_q.pc         <= base_pc;
      group_q.instrs     <= rsp_instrs_i;
      group_q.slot_valid <= slot_mask;
      group_q.pred_npc   <= pred_i.slot_npc;
    end
  end

  assign ibuf_valid_o = (state_q == S_PRESENT);
  assign ibuf_group_o = group_q;

endmodule

`default_nettype wire

// ==== hdl/bpu.sv ====
// Direct-mapped BTB with bimodal counters; no RAS or history, BTB_ENTRIES must be a power of two
`timescale 1ns/100ps
`default_nettype none

module bpu
  import frontend_pkg::*;
#(
  parameter int unsigned BTB_ENTRIES = 64
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fetch_valid_i,
  input  logic        fetch_ready_i,
  input  fetch_req_t  fetch_req_i,
  input  logic        update_valid_i,
  input  bpu_update_t update_i,
  output pred_t       pred_o
);

  localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);

  logic [BTB_ENTRIES-1:0] btb_valid_q;
  logic [PLEN-1:0]        btb_tag_q    [BTB_ENTRIES];
  logic [PLEN-1:0]        btb_target_q [BTB_ENTRIES];
  logic                   btb_cond_q   [BTB_ENTRIES];
  logic [1:0]             btb_cnt_q    [BTB_ENTRIES];

  logic [PLEN-1:0]                       base_pc;
  logic [INSTR_PER_FETCH-1:0][PLEN-1:0]  slot_pc;
  logic [INSTR_PER_FETCH-1:0][IDX_W-1:0] slot_idx;
  logic [INSTR_PER_FETCH-1:0]            slot_taken;
  pred_t                                 pred_d;

  logic [IDX_W-1:0] upd_idx;
  logic             upd_hit;

  // ==================================================
  // Lookup of both slots
  // ==================================================
  assign base_pc = {fetch_req_i.pc[PLEN-1:GROUP_OFFSET_W], {GROUP_OFFSET_W{1'b0}}};

  always_comb begin
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      slot_pc[s]    = base_pc + PLEN'(4 * s);
      slot_idx[s]   = slot_pc[s][IDX_W+1:2];
      // Tag holds the full PC, so a hit is exact
      slot_taken[s] = (slot_pc[s] >= fetch_req_i.pc) &&
                      btb_valid_q[slot_idx[s]] &&
                      (btb_tag_q[slot_idx[s]] == slot_pc[s]) &&
                      (!btb_cond_q[slot_idx[s]] || btb_cnt_q[slot_idx[s]][1]);
    end

    pred_d     = '0;
    pred_d.npc = base_pc + PLEN'(GROUP_BYTES);
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      pred_d.slot_npc[s] = slot_pc[s] + PLEN'(4);
      // First taken slot wins
      if (slot_taken[s] && !pred_d.taken_valid) begin
        pred_d.taken_valid = 1'b1;
        pred_d.taken_slot  = SLOT_IDX_W'(s);
        pred_d.npc         = btb_target_q[slot_idx[s]];
        pred_d.slot_npc[s] = btb_target_q[slot_idx[s]];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pred_o <= '0;
    end else if (fetch_valid_i && fetch_ready_i) begin
      pred_o <= pred_d;
    end
  end

  // ==================================================
  // Training
  // ==================================================
  assign upd_idx = update_i.pc[IDX_W+1:2];
  assign upd_hit = btb_valid_q[upd_idx] && (btb_tag_q[upd_idx] == update_i.pc);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      btb_valid_q <= '0;
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_cnt_q[i] <= 2'd1;
      end
    end else if (update_valid_i) begin
      if (update_i.taken) begin
        btb_valid_q[upd_idx] <= 1'b1;
        if (!upd_hit) begin
          // New entry starts weakly taken
          btb_cnt_q[upd_idx] <= 2'd2;
        end else if (btb_cnt_q[upd_idx] != 2'd3) begin
          btb_cnt_q[upd_idx] <= btb_cnt_q[upd_idx] + 2'd1;
        end
      end else if (upd_hit && btb_cnt_q[upd_idx] != 2'd0) begin
        btb_cnt_q[upd_idx] <= btb_cnt_q[upd_idx] - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_valid_i && update_i.taken) begin
      btb_tag_q[upd_idx]    <= update_i.pc;
      btb_target_q[upd_idx] <= update_i.target;
      btb_cond_q[upd_idx]   <= update_i.is_cond;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/icache.sv ====
// Two-way I-cache; one outstanding miss, no invalidation, refill must carry the requested line and way
`timescale 1ns/100ps
`default_nettype none

module icache
  import frontend_pkg::*;
#(
  parameter int unsigned ICACHE_SETS = 16
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 req_valid_i,
  input  fetch_req_t                           req_i,
  input  logic                                 flush_i,
  input  logic                                 miss_ready_i,
  input  logic                                 refill_valid_i,
  input  refill_t                              refill_i,
  output logic                                 req_ready_o,
  output logic                                 rsp_valid_o,
  output logic [INSTR_PER_FETCH-1:0][ILEN-1:0] rsp_instrs_o,
  output logic                                 miss_valid_o,
  output miss_req_t                            miss_req_o,
  output logic                                 refill_ready_o
);

  localparam int unsigned INDEX_W    = $clog2(ICACHE_SETS);
  localparam int unsigned TAG_W      = PLEN - INDEX_W - LINE_OFFSET_W;
  localparam int unsigned GROUP_BITS = INSTR_PER_FETCH * ILEN;

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_LOOKUP  = 3'd1;
  localparam logic [2:0] S_MISS    = 3'd2;
  localparam logic [2:0] S_REFILL  = 3'd3;
  localparam logic [2:0] S_RESPOND = 3'd4;

  logic [TAG_W-1:0]       tag_q   [ICACHE_WAYS][ICACHE_SETS];
  logic [LINE_WIDTH-1:0]  data_q  [ICACHE_WAYS][ICACHE_SETS];
  logic [ICACHE_WAYS-1:0] valid_q [ICACHE_SETS];
  logic [ICACHE_SETS-1:0] rr_q;

  logic [2:0]             state_q;
  logic                   flushed_q;
  logic [PLEN-1:0]        addr_q;
  logic [GROUP_BITS-1:0]  rsp_q;

  logic [INDEX_W-1:0]     set_idx;
  logic [TAG_W-1:0]       req_tag;
  logic [INDEX_W-1:0]     refill_idx;
  logic [ICACHE_WAYS-1:0] way_hit;
  logic                   hit;
  logic                   victim;
  logic                   refill_fire;
  logic [LINE_WIDTH-1:0]  hit_line;
  logic [GROUP_BITS-1:0]  lookup_instrs;

  // ==================================================
  // Hit check and victim choice
  // ==================================================
  assign set_idx    = addr_q[LINE_OFFSET_W +: INDEX_W];
  assign req_tag    = addr_q[PLEN-1 -: TAG_W];
  assign refill_idx = refill_i.paddr[LINE_OFFSET_W +: INDEX_W];

  always_comb begin
    for (int w = 0; w < ICACHE_WAYS; w++) begin
      way_hit[w] = valid_q[set_idx][w] && (tag_q[w][set_idx] == req_tag);
    end
  end

  assign hit      = |way_hit;
  assign hit_line = data_q[way_hit[1]][set_idx];
  // Two groups per line, picked by the group offset bit
  assign lookup_instrs =
    hit_line[addr_q[LINE_OFFSET_W-1:GROUP_OFFSET_W] * GROUP_BITS +: GROUP_BITS];

  // Empty way first, then round robin
  assign victim = !valid_q[set_idx][0] ? 1'b0 :
                  !valid_q[set_idx][1] ? 1'b1 : rr_q[set_idx];

  // ==================================================
  // Miss state machine
  // ==================================================
  assign req_ready_o    = (state_q == S_IDLE);
  assign refill_ready_o = (state_q == S_REFILL);
  assign refill_fire    = refill_valid_i && refill_ready_o;

  assign miss_valid_o     = (state_q == S_LOOKUP && !hit && !flush_i) || (state_q == S_MISS);
  assign miss_req_o.paddr = {addr_q[PLEN-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
  assign miss_req_o.way   = victim;

  assign rsp_valid_o  = !flush_i && ((state_q == S_LOOKUP && hit) || (state_q == S_RESPOND));
  assign rsp_instrs_o = (state_q == S_RESPOND) ? rsp_q : lookup_instrs;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      flushed_q <= 1'b0;
    end else begin
      // A flush during the miss is remembered until the refill lands
      flushed_q <= (state_q == S_MISS || state_q == S_REFILL) && (flushed_q || flush_i);
      case (state_q)
        S_IDLE: begin
          if (req_valid_i) begin
            state_q <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (flush_i || hit) begin
            state_q <= S_IDLE;
          end else if (miss_ready_i) begin
            state_q <= S_REFILL;
          end else begin
            state_q <= S_MISS;
          end
        end
        S_MISS: begin
          if (miss_ready_i) begin
            state_q <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (refill_valid_i) begin
            state_q <= (flushed_q || flush_i) ? S_IDLE : S_RESPOND;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      addr_q <= req_i.pc;
    end
    if (refill_fire) begin
      rsp_q <= refill_i.data[addr_q[LINE_OFFSET_W-1:GROUP_OFFSET_W] * GROUP_BITS +: GROUP_BITS];
    end
  end

  // ==================================================
  // Refill write
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (refill_fire) begin
      tag_q[refill_i.way][refill_idx]  <= refill_i.paddr[PLEN-1 -: TAG_W];
      data_q[refill_i.way][refill_idx] <= refill_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
      for (int s = 0; s < ICACHE_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (refill_fire) begin
      valid_q[refill_idx][refill_i.way] <= 1'b1;
      rr_q[refill_idx]                  <= ~rr_q[refill_idx];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/frontend.sv ====
// Fetch frontend top; a single miss may be outstanding and the refill must echo its way
`timescale 1ns/100ps
`default_nettype none

module frontend
  import frontend_pkg::*;
#(
  parameter int unsigned BTB_ENTRIES = 64,
  parameter int unsigned ICACHE_SETS = 16
) (
  input  logic            clk_i,
  input  logic            rst_n_i,

  // ==================================================
  // Instruction buffer and backend control
  // ==================================================
  output logic            ibuf_valid_o,
  input  logic            ibuf_ready_i,
  output fetch_group_t    ibuf_group_o,

  input  logic            flush_i,
  input  logic [PLEN-1:0] redirect_pc_i,
  input  logic            bpu_update_valid_i,
  input  bpu_update_t     bpu_update_i,

  // ==================================================
  // Memory side
  // ==================================================
  output logic            miss_valid_o,
  input  logic            miss_ready_i,
  output miss_req_t       miss_req_o,

  input  logic            refill_valid_i,
  output logic            refill_ready_o,
  input  refill_t         refill_i
);

  // Fetch request shared by predictor and cache
  logic                                 fetch_valid;
  fetch_req_t                           fetch_req;
  logic                                 req_ready;

  pred_t                                pred;

  logic                                 rsp_valid;
  logic [INSTR_PER_FETCH-1:0][ILEN-1:0] rsp_instrs;
  logic                                 cache_flush;

  ifu u_ifu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ibuf_ready_i  (ibuf_ready_i),
    .flush_i       (flush_i),
    .redirect_pc_i (redirect_pc_i),
    .req_ready_i   (req_ready),
    .pred_i        (pred),
    .rsp_valid_i   (rsp_valid),
    .rsp_instrs_i  (rsp_instrs),
    .fetch_valid_o (fetch_valid),
    .fetch_req_o   (fetch_req),
    .cache_flush_o (cache_flush),
    .ibuf_valid_o  (ibuf_valid_o),
    .ibuf_group_o  (ibuf_group_o)
  );

  bpu #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_bpu (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_valid_i  (fetch_valid),
    .fetch_ready_i  (req_ready),
    .fetch_req_i    (fetch_req),
    .update_valid_i (bpu_update_valid_i),
    .update_i       (bpu_update_i),
    .pred_o         (pred)
  );

  icache #(
    .ICACHE_SETS (ICACHE_SETS)
  ) u_icache (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (fetch_valid),
    .req_i          (fetch_req),
    .flush_i        (cache_flush),
    .miss_ready_i   (miss_ready_i),
    .refill_valid_i (refill_valid_i),
    .refill_i       (refill_i),
    .req_ready_o    (req_ready),
    .rsp_valid_o    (rsp_valid),
    .rsp_instrs_o   (rsp_instrs),
    .miss_valid_o   (miss_valid_o),
    .miss_req_o     (miss_req_o),
    .refill_ready_o (refill_ready_o)
  );

endmodule

`default_nettype wire

// ==== sim/frontend_checker.sv ====
// Handshake assertions for the frontend top; only meaningful once reset has been released
`timescale 1ns/100ps
`default_nettype none

module frontend_checker
  import frontend_pkg::*;
(
  input wire logic         clk_i,
  input wire logic         rst_n_i,
  input wire logic         ibuf_valid_o,
  input wire logic         ibuf_ready_i,
  input wire fetch_group_t ibuf_group_o,
  input wire logic         miss_valid_o,
  input wire logic         miss_ready_i,
  input wire miss_req_t    miss_req_o,
  input wire logic         refill_ready_o
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Stalled buffer output must hold
  a_ibuf_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ibuf_valid_o && !ibuf_ready_i) |=> $stable(ibuf_group_o))
    else begin
      fail_count++;
      $error("ibuf_group_o changed while stalled");
    end

  // Stalled miss request must hold
  a_miss_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (miss_valid_o && !miss_ready_i) |=> $stable(miss_req_o))
    else begin
      fail_count++;
      $error("miss_req_o changed while stalled");
    end

  a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({ibuf_valid_o, miss_valid_o, refill_ready_o}))
    else begin
      fail_count++;
      $error("handshake output is unknown after reset");
    end

endmodule

`default_nettype wire

// ==== sim/frontend_tb.sv ====
// Frontend testbench; assumes default parameters (64 BTB entries, 16 sets) and one miss at a time
`timescale 1ns/100ps
`default_nettype none

module frontend_tb
  import frontend_pkg::*;
();

  localparam logic [31:0] PATTERN         = 32'h5A5A_0000;
  localparam int          GROUPS_EXPECTED = 66;
  localparam int          MISSES_EXPECTED = 19;
  localparam int          CYCLE_LIMIT     = 20 * (GROUPS_EXPECTED + MISSES_EXPECTED) + 200;

  logic         clk_i;
  logic         rst_n_i;
  logic         ibuf_valid_o;
  logic         ibuf_ready_i;
  fetch_group_t ibuf_group_o;
  logic         flush_i;
  logic [31:0]  redirect_pc_i;
  logic         bpu_update_valid_i;
  bpu_update_t  bpu_update_i;
  logic         miss_valid_o;
  logic         miss_ready_i;
  miss_req_t    miss_req_o;
  logic         refill_valid_i;
  logic         refill_ready_o;
  refill_t      refill_i;

  int           seed = 67171;
  int           errors;
  int           cycles;
  int           accepted;
  logic [31:0]  exp_pc;
  logic [31:0]  miss_addr [$];
  logic         miss_way  [$];
  bit           line_seen [logic [31:0]];

  // Testbench copy of the BTB
  logic         btb_valid  [64];
  logic [31:0]  btb_tag    [64];
  logic [31:0]  btb_target [64];
  logic         btb_cond   [64];
  logic [1:0]   btb_cnt    [64];

  frontend u_dut (.*);

  bind frontend frontend_checker u_checker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ibuf_valid_o   (ibuf_valid_o),
    .ibuf_ready_i   (ibuf_ready_i),
    .ibuf_group_o   (ibuf_group_o),
    .miss_valid_o   (miss_valid_o),
    .miss_ready_i   (miss_ready_i),
    .miss_req_o     (miss_req_o),
    .refill_ready_o (refill_ready_o)
  );

  always #2 clk_i = ~clk_i;

  // ==================================================
  // Reference model
  // ==================================================
  function automatic fetch_group_t ref_group(input logic [31:0] pc);
    fetch_group_t g;
    logic [31:0]  spc;
    logic [5:0]   idx;
    logic         taken_seen;
    g          = '0;
    taken_seen = 1'b0;
    g.pc       = {pc[31:3], 3'b000};
    for (int s = 0; s < 2; s++) begin
      spc             = g.pc + 32'(4 * s);
      idx             = spc[7:2];
      g.instrs[s]     = spc ^ PATTERN;
      g.pred_npc[s]   = spc + 32'd4;
      g.slot_valid[s] = (spc >= pc) && !taken_seen;
      if (g.slot_valid[s] && btb_valid[idx] && btb_tag[idx] == spc &&
          (!btb_cond[idx] || btb_cnt[idx] >= 2'd2)) begin
        taken_seen    = 1'b1;
        g.pred_npc[s] = btb_target[idx];
      end
    end
    return g;
  endfunction

  // Next fetch PC follows the last valid slot
  function automatic logic [31:0] group_next_pc(input fetch_group_t g);
    logic [31:0] n;
    n = g.pc + 32'd8;
    for (int s = 0; s < 2; s++) begin
      if (g.slot_valid[s]) begin
        n = g.pred_npc[s];
      end
    end
    return n;
  endfunction

  function automatic logic [127:0] line_data(input logic [31:0] addr);
    logic [127:0] d;
    for (int k = 0; k < 4; k++) begin
      d[k*32 +: 32] = (addr + 32'(4 * k)) ^ PATTERN;
    end
    return d;
  endfunction

  // ==================================================
  // Monitor, memory model and timeout
  // ==================================================
  always @(posedge clk_i) begin : monitor
    fetch_group_t g;
    if (rst_n_i) begin
      if (ibuf_valid_o && ibuf_ready_i) begin
        g = ref_group(exp_pc);
        if (ibuf_group_o.pc !== g.pc) begin
          errors++;
          $display("error ibuf_group_o.pc expected %h got %h", g.pc, ibuf_group_o.pc);
        end
        if (ibuf_group_o.instrs !== g.instrs) begin
          errors++;
          $display("error ibuf_group_o.instrs expected %h got %h", g.instrs,
                   ibuf_group_o.instrs);
        end
        if (ibuf_group_o.slot_valid !== g.slot_valid) begin
          errors++;
          $display("error ibuf_group_o.slot_valid expected %h got %h", g.slot_valid,
                   ibuf_group_o.slot_valid);
        end
        if (ibuf_group_o.pred_npc !== g.pred_npc) begin
          errors++;
          $display("error ibuf_group_o.pred_npc expected %h got %h", g.pred_npc,
                   ibuf_group_o.pred_npc);
        end
        exp_pc = group_next_pc(g);
        accepted++;
      end
      if (flush_i) begin
        exp_pc = redirect_pc_i;
      end
    end
  end

  initial begin : memory_model
    int          delay;
    logic [31:0] addr;
    logic        way;
    forever begin
      @(posedge clk_i);
      if (rst_n_i && miss_valid_o) begin
        delay = 1 + ($unsigned($random(seed)) % 6);
        repeat (delay - 1) @(posedge clk_i);
        #1 miss_ready_i = 1'b1;
        @(posedge clk_i);
        addr = miss_req_o.paddr;
        way  = miss_req_o.way;
        #1 miss_ready_i = 1'b0;
        if (addr[3:0] != 4'h0) begin
          errors++;
          $display("error miss_req_o.paddr not line aligned %h", addr);
        end
        if (line_seen.exists(addr)) begin
          errors++;
          $display("line %h missed a second time", addr);
        end
        line_seen[addr] = 1'b1;
        miss_addr.push_back(addr);
        miss_way.push_back(way);
        delay = 1 + ($unsigned($random(seed)) % 6);
        repeat (delay) @(posedge clk_i);
        #1;
        refill_valid_i = 1'b1;
        refill_i.paddr = addr;
        refill_i.way   = way;
        refill_i.data  = line_data(addr);
        @(posedge clk_i);
        while (!refill_ready_o) @(posedge clk_i);
        #1 refill_valid_i = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped by timeout after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // ==================================================
  // Stimulus tasks
  // ==================================================
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_groups(input int n, input bit rnd);
    int          target;
    logic [31:0] word;
    target = accepted + n;
    while (accepted < target) begin
      word         = $random(seed);
      ibuf_ready_i = rnd ? word[0] : 1'b1;
      next_cycle();
    end
    ibuf_ready_i = 1'b0;
  endtask

  // Leaves a presented group stalled and nothing in flight
  task automatic hold_fetch();
    ibuf_ready_i = 1'b0;
    while (!ibuf_valid_o) next_cycle();
  endtask

  task automatic redirect(input logic [31:0] pc);
    flush_i       = 1'b1;
    redirect_pc_i = pc;
    next_cycle();
    flush_i       = 1'b0;
  endtask

  task automatic train(input logic [31:0] pc, input logic cond, input logic taken,
                       input logic [31:0] target);
    logic [5:0] idx;
    logic       hit;
    idx                        = pc[7:2];
    hit                        = btb_valid[idx] && btb_tag[idx] == pc;
    bpu_update_valid_i         = 1'b1;
    bpu_update_i.pc            = pc;
    bpu_update_i.is_cond       = cond;
    bpu_update_i.taken         = taken;
    bpu_update_i.target        = target;
    next_cycle();
    bpu_update_valid_i = 1'b0;
    if (taken) begin
      btb_cnt[idx]    = !hit ? 2'd2 : (btb_cnt[idx] == 2'd3 ? 2'd3 : btb_cnt[idx] + 2'd1);
      btb_valid[idx]  = 1'b1;
      btb_tag[idx]    = pc;
      btb_target[idx] = target;
      btb_cond[idx]   = cond;
    end else if (hit && btb_cnt[idx] != 2'd0) begin
      btb_cnt[idx] = btb_cnt[idx] - 2'd1;
    end
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin : stimulus
    int m;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    ibuf_ready_i = 1'b0;
    flush_i = 1'b0;
    redirect_pc_i = '0;
    bpu_update_valid_i = 1'b0;
    bpu_update_i = '0;
    miss_ready_i = 1'b0;
    refill_valid_i = 1'b0;
    refill_i = '0;
    errors = 0;
    cycles = 0;
    accepted = 0;
    exp_pc = RESET_PC;
    for (int i = 0; i < 64; i++) begin
      btb_valid[i] = 1'b0;
      btb_cnt[i]   = 2'd1;
    end
    repeat (8) @(posedge clk_i);
    #1 rst_n_i = 1'b1;

    // Sequential fetch, one miss per line
    run_groups(16, 1'b0);
    hold_fetch();
    if (miss_addr.size() != 9) begin
      errors++;
      $display("expected 9 misses on the first pass but saw %0d", miss_addr.size());
    end

    // Cached loop again
    m = miss_addr.size();
    redirect(RESET_PC);
    run_groups(16, 1'b0);
    hold_fetch();
    if (miss_addr.size() != m) begin
      errors++;
      $display("re-fetch of a cached loop caused %0d misses", miss_addr.size() - m);
    end

    // Unaligned redirect while stalled, then while a request is in flight
    redirect(32'h0000_1024);
    run_groups(4, 1'b0);
    ibuf_ready_i = 1'b1;
    redirect(32'h0000_1044);
    run_groups(4, 1'b0);
    hold_fetch();

    // Back-pressure over cached lines
    redirect(RESET_PC);
    run_groups(14, 1'b1);
    hold_fetch();

    // Branch training
    train(32'h0000_1100, 1'b1, 1'b1, 32'h0000_1200);
    redirect(32'h0000_1100);
    run_groups(3, 1'b0);
    hold_fetch();
    train(32'h0000_1100, 1'b1, 1'b0, 32'h0);
    train(32'h0000_1100, 1'b1, 1'b0, 32'h0);
    redirect(32'h0000_1100);
    run_groups(3, 1'b0);
    hold_fetch();
    train(32'h0000_1304, 1'b0, 1'b1, 32'h0000_1400);
    // Counter falls below 2, the jump must still be taken
    train(32'h0000_1304, 1'b0, 1'b0, 32'h0);
    redirect(32'h0000_1300);
    run_groups(3, 1'b0);
    hold_fetch();

    // Three lines in set 12 get ways 0, 1, 0
    m = miss_addr.size();
    for (int k = 0; k < 3; k++) begin
      redirect(32'h0000_20C0 + 32'(k * 32'h100));
      run_groups(1, 1'b0);
      hold_fetch();
    end
    if (miss_addr.size() != m + 3) begin
      errors++;
      $display("expected 3 conflict misses but saw %0d", miss_addr.size() - m);
    end else begin
      for (int k = 0; k < 3; k++) begin
        if (miss_addr[m+k] !== 32'h0000_20C0 + 32'(k * 32'h100)) begin
          errors++;
          $display("error miss_req_o.paddr expected %h got %h",
                   32'h0000_20C0 + 32'(k * 32'h100), miss_addr[m+k]);
        end
        if (miss_way[m+k] !== 1'(k % 2)) begin
          errors++;
          $display("error miss_req_o.way expected %h got %h", 1'(k % 2), miss_way[m+k]);
        end
      end
    end

    repeat (4) next_cycle();
    errors += u_dut.u_checker.fail_count;
    $display("Run done: %0d errors, %0d groups, %0d misses", errors, accepted,
             miss_addr.size());
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== frontend.f ====
hdl/frontend_pkg.sv
hdl/ifu.sv
hdl/bpu.sv
hdl/icache.sv
hdl/frontend.sv
sim/frontend_checker.sv
sim/frontend_tb.sv
